// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= nnTb
BUILD_DIR ?= build

SOURCES := $(shell grep -v '^+' tb.f)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes.
$(BIN): tb.f $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f tb.f

run: $(BIN)
	@output="$$(./$(BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/classSelect.sv ====
module classSelect #(
	parameter int CLASSES = 3
) (
	input logic clk,
	input logic reset,
	input nnPkg::scoreVec_t scores,
	output nnPkg::result_t result
);

	nnPkg::activation_t bestScore;
	nnPkg::classId_t bestId;

	// A strict compare keeps the lowest index when scores are equal.
	always_comb
	begin
		bestScore = scores[0];
		bestId = '0;
		for (int i = 1; i < CLASSES; i++)
		begin
			if (scores[i] > bestScore)
			begin
				bestScore = scores[i];
				bestId = nnPkg::classId_t'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result.scores <= scores;
			result.classId <= bestId;
		end
	end

	// True when the registered class is the first index holding the top score.
	function automatic logic isFirstMax(nnPkg::result_t r);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < CLASSES; i++)
		begin
			if (i < int'(r.classId) && r.scores[i] >= r.scores[r.classId])
				ok = 1'b0;
			if (i > int'(r.classId) && r.scores[i] > r.scores[r.classId])
				ok = 1'b0;
		end
		return ok;
	endfunction

	classIdInRange: assert property (@(posedge clk) disable iff (reset)
		int'(result.classId) < CLASSES);

	classIdIsFirstMax: assert property (@(posedge clk) disable iff (reset)
		int'(result.classId) < CLASSES |-> isFirstMax(result));

endmodule

// ==== rtl/denseLayer.sv ====
module denseLayer #(
	parameter int FAN_IN = 15,
	parameter int NEURONS = 4,
	parameter nnPkg::weight_t [0:FAN_IN*NEURONS-1] WEIGHT_TABLE = '0,
	parameter nnPkg::bias_t [0:NEURONS-1] BIAS_TABLE = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::activation_t [FAN_IN-1:0] inputs,
	output nnPkg::activation_t [NEURONS-1:0] outputs
);

	// Every neuron sees the whole input vector and takes its own row of weights.
	for (genvar n = 0; n < NEURONS; n++)
	begin : gNeuron
		denseNeuron #(
			.FAN_IN(FAN_IN),
			.WEIGHTS(WEIGHT_TABLE[n*FAN_IN +: FAN_IN]),
			.BIAS(BIAS_TABLE[n])
		) neuron (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.activation(outputs[n])
		);
	end

endmodule

// ==== rtl/denseNeuron.sv ====
module denseNeuron #(
	parameter int FAN_IN = 15,
	parameter nnPkg::weight_t [0:FAN_IN-1] WEIGHTS = '0,
	parameter nnPkg::bias_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::activation_t [FAN_IN-1:0] inputs,
	output nnPkg::activation_t activation
);

	localparam int PRODUCT_WIDTH = nnPkg::ACT_WIDTH + nnPkg::WEIGHT_WIDTH;

	nnPkg::activation_t [FAN_IN-1:0] inputsReg;
	logic signed [PRODUCT_WIDTH-1:0] products [FAN_IN];
	nnPkg::acc_t sumNext;
	nnPkg::acc_t sumReg;
	nnPkg::acc_t shifted;
	nnPkg::acc_t rounded;
	nnPkg::activation_t activationNext;

	// ====================
	// Multiply and accumulate
	// ====================

	always_comb
	begin
		for (int i = 0; i < FAN_IN; i++)
		begin
			products[i] = PRODUCT_WIDTH'(inputsReg[i]) * PRODUCT_WIDTH'(WEIGHTS[i]);
		end
	end

	// The bias is already on the scale of a single product.
	always_comb
	begin
		sumNext = nnPkg::acc_t'(BIAS);
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + nnPkg::acc_t'(products[i]);
		end
	end

	// ====================
	// Activation
	// ====================

	// Round half up after the shift, then clamp to the positive 7-bit range.
	always_comb
	begin
		shifted = sumReg >>> nnPkg::FRAC_BITS;
		rounded = shifted + nnPkg::acc_t'({1'b0, sumReg[nnPkg::FRAC_BITS-1]});
		if (sumReg[nnPkg::ACC_WIDTH-1])
			activationNext = '0;
		else if (rounded > nnPkg::acc_t'(nnPkg::ACT_MAX))
			activationNext = nnPkg::activation_t'(nnPkg::ACT_MAX);
		else
			activationNext = rounded[nnPkg::ACT_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sumReg <= sumNext;
			activation <= activationNext;
		end
	end

	activationInRange: assert property (@(posedge clk) disable iff (reset)
		!activation[nnPkg::ACT_WIDTH-1]
		&& activation <= nnPkg::activation_t'(nnPkg::ACT_MAX));

endmodule

// ==== rtl/nnPkg.sv ====
package nnPkg;

	// ====================
	// Widths and scaling
	// ====================

	parameter int ACT_WIDTH = 8;
	parameter int WEIGHT_WIDTH = 8;
	parameter int BIAS_WIDTH = 16;
	parameter int ACC_WIDTH = 23;
	parameter int CLASS_ID_WIDTH = 2;

	// An accumulator value divided by 2**FRAC_BITS is an activation.
	parameter int FRAC_BITS = 6;
	parameter int ACT_MAX = 127;

	// ====================
	// Layer sizes and types
	// ====================

	parameter int NUM_FEATURES = 15;
	parameter int NUM_HIDDEN = 4;
	parameter int NUM_CLASSES = 3;

	typedef logic signed [ACT_WIDTH-1:0] activation_t;
	typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
	typedef logic signed [BIAS_WIDTH-1:0] bias_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	typedef activation_t [NUM_FEATURES-1:0] featureVec_t;
	typedef activation_t [NUM_HIDDEN-1:0] hiddenVec_t;
	typedef activation_t [NUM_CLASSES-1:0] scoreVec_t;

	typedef logic [CLASS_ID_WIDTH-1:0] classId_t;

	typedef struct packed {
		scoreVec_t scores;
		classId_t classId;
	} result_t;

	// ====================
	// Weight and bias tables
	// ====================

	// Entry n*FAN_IN+i is the weight of input i into neuron n.
	parameter weight_t [0:NUM_HIDDEN*NUM_FEATURES-1] HIDDEN_WEIGHTS = '{
		8'sd16, -8'sd19, 8'sd21, -8'sd23, 8'sd8,
		8'sd2, 8'sd25, -8'sd31, 8'sd7, 8'sd31,
		8'sd31, 8'sd29, -8'sd19, -8'sd31, 8'sd2,
		8'sd12, 8'sd9, -8'sd14, 8'sd5, 8'sd22,
		-8'sd7, 8'sd3, 8'sd18, -8'sd25, 8'sd11,
		-8'sd6, 8'sd27, 8'sd14, -8'sd9, 8'sd20,
		-8'sd8, 8'sd24, 8'sd6, -8'sd17, -8'sd3,
		8'sd30, -8'sd12, 8'sd10, 8'sd19, -8'sd22,
		8'sd4, -8'sd15, 8'sd28, 8'sd7, -8'sd11,
		8'sd5, -8'sd10, 8'sd13, 8'sd26, -8'sd20,
		8'sd15, 8'sd9, -8'sd4, -8'sd18, 8'sd23,
		8'sd17, -8'sd2, -8'sd27, 8'sd12, 8'sd8
	};

	parameter bias_t [0:NUM_HIDDEN-1] HIDDEN_BIAS = '{
		16'sd512, -16'sd256, 16'sd320, 16'sd0
	};

	parameter weight_t [0:NUM_CLASSES*NUM_HIDDEN-1] OUTPUT_WEIGHTS = '{
		8'sd20, -8'sd12, 8'sd15, 8'sd9,
		-8'sd8, 8'sd25, 8'sd10, -8'sd14,
		8'sd14, 8'sd6, -8'sd18, 8'sd22
	};

	parameter bias_t [0:NUM_CLASSES-1] OUTPUT_BIAS = '{
		16'sd128, -16'sd64, 16'sd0
	};

endpackage

// ==== rtl/nnTop.sv ====
module nnTop (
	input logic clk,
	input logic reset,
	input nnPkg::featureVec_t features,
	output nnPkg::result_t result
);

	// Each layer adds three register stages and the selector one more,
	// so a feature vector reaches result six edges after it is sampled.

	nnPkg::hiddenVec_t hiddenActs;
	nnPkg::scoreVec_t scores;

	// ====================
	// Hidden layer
	// ====================

	denseLayer #(
		.FAN_IN(nnPkg::NUM_FEATURES),
		.NEURONS(nnPkg::NUM_HIDDEN),
		.WEIGHT_TABLE(nnPkg::HIDDEN_WEIGHTS),
		.BIAS_TABLE(nnPkg::HIDDEN_BIAS)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.outputs(hiddenActs)
	);

	// ====================
	// Output layer
	// ====================

	denseLayer #(
		.FAN_IN(nnPkg::NUM_HIDDEN),
		.NEURONS(nnPkg::NUM_CLASSES),
		.WEIGHT_TABLE(nnPkg::OUTPUT_WEIGHTS),
		.BIAS_TABLE(nnPkg::OUTPUT_BIAS)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenActs),
		.outputs(scores)
	);

	classSelect #(
		.CLASSES(nnPkg::NUM_CLASSES)
	) selector (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.result(result)
	);

endmodule

// ==== sim/nnTb.sv ====
module nnTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int STIM_DELAY = 5;
	localparam int RESET_CYCLES = 10;
	localparam int LATENCY = 6;
	localparam int RANDOM_COUNT = 200;
	localparam int FILE_FIELDS = nnPkg::NUM_FEATURES + nnPkg::NUM_CLASSES + 1;
	localparam string VECTOR_FILE = "sim/nnVectors.txt";

	logic clk;
	logic reset;
	nnPkg::featureVec_t features;
	nnPkg::result_t result;

	nnPkg::featureVec_t fileFeatures[$];
	nnPkg::result_t fileExpected[$];
	nnPkg::result_t expQ[$];
	bit checkQ[$];

	logic [31:0] lfsrState;
	bit vectorsLoaded;
	int scoreErrors;
	int classErrors;
	int otherErrors;
	int checkedCount;

	nnTop dut0 (
		.clk(clk),
		.reset(reset),
		.features(features),
		.result(result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ====================
	// Reference model
	// ====================

	// Negative sums give zero, then divide by 64 rounding half up and clamp at 127.
	function automatic nnPkg::activation_t activate(input int sum);
		int q;
		if (sum < 0)
			return '0;
		q = (sum >> nnPkg::FRAC_BITS) + ((sum >> (nnPkg::FRAC_BITS - 1)) & 1);
		if (q > nnPkg::ACT_MAX)
			q = nnPkg::ACT_MAX;
		return nnPkg::activation_t'(q);
	endfunction

	function automatic nnPkg::result_t expectedResult(input nnPkg::featureVec_t f);
		nnPkg::hiddenVec_t h;
		nnPkg::result_t r;
		int sum;
		for (int n = 0; n < nnPkg::NUM_HIDDEN; n++)
		begin
			sum = int'(nnPkg::HIDDEN_BIAS[n]);
			for (int i = 0; i < nnPkg::NUM_FEATURES; i++)
				sum += int'(f[i]) * int'(nnPkg::HIDDEN_WEIGHTS[n * nnPkg::NUM_FEATURES + i]);
			h[n] = activate(sum);
		end
		for (int c = 0; c < nnPkg::NUM_CLASSES; c++)
		begin
			sum = int'(nnPkg::OUTPUT_BIAS[c]);
			for (int i = 0; i < nnPkg::NUM_HIDDEN; i++)
				sum += int'(h[i]) * int'(nnPkg::OUTPUT_WEIGHTS[c * nnPkg::NUM_HIDDEN + i]);
			r.scores[c] = activate(sum);
		end
		// Lowest index wins a tie.
		r.classId = '0;
		for (int c = 1; c < nnPkg::NUM_CLASSES; c++)
		begin
			if (r.scores[c] > r.scores[r.classId])
				r.classId = nnPkg::classId_t'(c);
		end
		return r;
	endfunction

	// ====================
	// Random source
	// ====================

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic randomByte(output nnPkg::activation_t b);
		b = '0;
		for (int k = 0; k < nnPkg::ACT_WIDTH; k++)
		begin
			lfsrState = lfsrNext(lfsrState);
			b = {b[nnPkg::ACT_WIDTH-2:0], lfsrState[0]};
		end
	endtask

	// ====================
	// Checks
	// ====================

	task automatic checkScores(input nnPkg::scoreVec_t exp, input nnPkg::scoreVec_t act,
		input string what);
		if (exp !== act)
		begin
			scoreErrors++;
			$display("ERROR %0t: %s scores expected %h, got %h", $time, what, exp, act);
		end
	endtask

	task automatic checkClass(input nnPkg::classId_t exp, input nnPkg::classId_t act,
		input string what);
		if (exp !== act)
		begin
			classErrors++;
			$display("ERROR %0t: %s classId expected %0d, got %0d", $time, what, exp, act);
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	task automatic loadVectors();
		int fd;
		int code;
		int fields[FILE_FIELDS];
		string line;
		nnPkg::featureVec_t f;
		nnPkg::result_t r;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open the vector file %s.", VECTOR_FILE);
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#")
				continue;
			code = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
				fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
				fields[12], fields[13], fields[14], fields[15], fields[16], fields[17],
				fields[18]);
			if (code != FILE_FIELDS)
			begin
				otherErrors++;
				$display("A line of the vector file has %0d fields instead of %0d.",
					code, FILE_FIELDS);
				continue;
			end
			for (int i = 0; i < nnPkg::NUM_FEATURES; i++)
				f[i] = nnPkg::activation_t'(fields[i]);
			for (int c = 0; c < nnPkg::NUM_CLASSES; c++)
				r.scores[c] = nnPkg::activation_t'(fields[nnPkg::NUM_FEATURES + c]);
			r.classId = nnPkg::classId_t'(fields[FILE_FIELDS - 1]);
			// The hand-computed lines also keep the reference model honest.
			if (expectedResult(f) !== r)
			begin
				otherErrors++;
				$display("The reference model disagrees with file vector %0d.",
					fileFeatures.size());
			end
			fileFeatures.push_back(f);
			fileExpected.push_back(r);
		end
		$fclose(fd);
		vectorsLoaded = 1'b1;
	endtask

	// A vector driven after one edge is sampled on the next and shows up in
	// result six edges later, so the queue holds LATENCY + 1 entries.
	task automatic nextCycle(input nnPkg::featureVec_t f, input nnPkg::result_t exp,
		input bit doCheck);
		nnPkg::result_t due;
		bit dueCheck;
		@(posedge clk);
		#STIM_DELAY;
		if (expQ.size() == LATENCY + 1)
		begin
			due = expQ.pop_front();
			dueCheck = checkQ.pop_front();
			if (dueCheck)
			begin
				checkScores(due.scores, result.scores, "pipeline");
				checkClass(due.classId, result.classId, "pipeline");
				checkedCount++;
			end
		end
		features = f;
		expQ.push_back(exp);
		checkQ.push_back(doCheck);
	endtask

	task automatic runTests();
		nnPkg::featureVec_t f;
		nnPkg::activation_t b;
		repeat (RESET_CYCLES)
		begin
			@(posedge clk);
			#STIM_DELAY;
			checkScores('0, result.scores, "reset");
			checkClass('0, result.classId, "reset");
		end
		reset = 1'b0;

		foreach (fileFeatures[n])
			nextCycle(fileFeatures[n], fileExpected[n], 1'b1);

		for (int n = 0; n < RANDOM_COUNT; n++)
		begin
			for (int i = 0; i < nnPkg::NUM_FEATURES; i++)
			begin
				randomByte(b);
				f[i] = b;
			end
			nextCycle(f, expectedResult(f), 1'b1);
		end

		repeat (LATENCY + 1)
			nextCycle('0, '0, 1'b0);
	endtask

	// ====================
	// Run control
	// ====================

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		features = '0;
		lfsrState = 32'h4ba5_3a48;
		vectorsLoaded = 1'b0;
		scoreErrors = 0;
		classErrors = 0;
		otherErrors = 0;
		checkedCount = 0;
		loadVectors();
		if (!vectorsLoaded)
		begin
			$display("Test FAILED");
			$finish;
		end
		else
		begin
			runTests();
			$display("Checked %0d vectors: %0d score errors, %0d class errors, %0d other errors",
				checkedCount, scoreErrors, classErrors, otherErrors);
			if (scoreErrors == 0 && classErrors == 0 && otherErrors == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
			$finish;
		end
	end

	initial
	begin
		wait (vectorsLoaded);
		#((fileFeatures.size() + RANDOM_COUNT + 20) * CLK_PERIOD);
		$display("Timeout: the run did not finish in the expected number of cycles.");
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== sim/nnVectors.txt ====
# Columns: feature0 .. feature14 (signed decimal), score0 score1 score2, classId.
# Lines starting with # are skipped.
#
# All zero inputs give the activated biases.
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0
# Feature 7 drives hidden neuron 0 far negative, so it clamps to 0.
0 0 0 0 0 0 0 127 0 0 0 0 0 0 0 2 15 0 1
# Feature 9 alone, several sums round up on bit 5.
0 0 0 0 0 0 0 0 0 127 0 0 0 0 0 27 0 33 2
# Features 9 to 11 saturate hidden neuron 0 at 127; neuron 1 sits exactly on a half.
0 0 0 0 0 0 0 0 0 127 127 127 0 0 0 41 0 59 2
# Tie between class 0 and class 2.
0 0 0 25 0 0 0 0 0 0 0 0 0 0 0 3 0 3 0
# Tie between class 1 and class 2.
0 0 0 0 0 -10 0 12 -22 0 0 0 0 0 0 1 2 2 1
# All ones.
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 6 0 1 0
# Repeats run back to back.
0 0 0 0 0 0 0 0 0 127 127 127 0 0 0 41 0 59 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0
0 0 0 0 0 -10 0 12 -22 0 0 0 0 0 0 1 2 2 1
0 0 0 0 0 0 0 127 0 0 0 0 0 0 0 2 15 0 1
0 0 0 25 0 0 0 0 0 0 0 0 0 0 0 3 0 3 0

// ==== tb.f ====
rtl/nnPkg.sv
rtl/denseNeuron.sv
rtl/denseLayer.sv
rtl/classSelect.sv
rtl/nnTop.sv
sim/nnTb.sv
